//--- tb/pad_stimulus.txt
// One frame per line, all values hex
// ID  vib_sw  byte3 byte4 byte5 byte6 byte7 byte8
// Digital rows carry stray bytes 5 to 8 that the pad never gets to send
41 0 FF FF 11 22 33 44
73 1 7F 80 12 34 A5 5A
41 2 FE 7F 99 88 77 66
53 0 01 02 03 04 05 06
23 3 80 7F FF 00 C3 3C
// IDs close to the analog set but digital
43 0 EF BE 01 02 03 04
E3 2 AA 55 11 22 33 44
F3 0 90 81 72 63 54 45
79 1 00 FF 10 20 30 40
12 3 5A A5 DE AD BE EF

//--- filelist.f
common/psx_pkg.sv
link/psx_frame_timer.sv
link/psx_serial_io.sv
src/psx_poll_command.sv
src/psx_response_store.sv
src/psx_pad_top.sv
tb/psx_pad_asserts.sv
tb/psx_pad_tb.sv

//--- Makefile
# Verilator flow for the PlayStation pad poller

TOP := psx_pad_tb

.PHONY: all lint sim clean

all: sim

# RTL with all warnings, then the testbench with the default set
lint:
	verilator --lint-only -Wall --timing --top-module psx_pad_top -f filelist.f
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

# Keep running past assertion failures so the summary line is printed
sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/psx_pad_tb.sv
// Pad poller testbench with clock, reset, file-driven pad model, checks and final report
`timescale 1ns/10ps
`default_nettype none

module psx_pad_tb;

   localparam int TIMER_BITS   = 10;
   localparam int NUM_FRAMES   = 10;
   localparam int COLS         = 8;   // ID, vib_sw, six response bytes
   localparam int FRAME_CYCLES = 1 << TIMER_BITS;
   localparam int MAX_CYCLES   = (NUM_FRAMES + 2) * FRAME_CYCLES;

   logic               I_CLK;
   logic               I_RSTn;
   logic               ps_rxd;
   logic [1:0]         vib_sw;
   logic               ps_clk;
   logic               ps_sel;
   logic               ps_txd;
   psx_pkg::pad_data_t pad_data;
   logic               pad_analog;
   logic               frame_done;

   logic [7:0]  stim [0:NUM_FRAMES*COLS-1];
   logic [7:0]  reply [0:8];     // What the pad answers this frame
   logic [7:0]  tx_seen [0:8];   // Command bytes decoded from ps_txd
   int          bit_cnt = 0;
   int          value_cnt = 0;
   int          other_cnt = 0;
   int          cycle_cnt = 0;
   logic [47:0] last_data = '0;
   logic        done_prev = 1'b0;

   psx_pad_top #(
      .TIMER_BITS (TIMER_BITS)
   ) psx_pad_top_i (
      .I_CLK      (I_CLK),
      .I_RSTn     (I_RSTn),
      .ps_rxd     (ps_rxd),
      .vib_sw     (vib_sw),
      .ps_clk     (ps_clk),
      .ps_sel     (ps_sel),
      .ps_txd     (ps_txd),
      .pad_data   (pad_data),
      .pad_analog (pad_analog),
      .frame_done (frame_done)
   );

   bind psx_pad_top psx_pad_asserts psx_pad_asserts_i (
      .I_CLK      (I_CLK),
      .I_RSTn     (I_RSTn),
      .ps_clk     (ps_clk),
      .ps_sel     (ps_sel),
      .ps_txd     (ps_txd),
      .frame_done (frame_done),
      .pad_data   (pad_data)
   );

   initial begin
      I_CLK = 1'b0;
      forever #5 I_CLK = ~I_CLK;
   end

   // ----------------------------------------
   // Reporting and reference rules
   // ----------------------------------------
   task automatic value_error(input string name, input logic [47:0] expected,
                              input logic [47:0] actual);
      value_cnt++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
   endtask

   task automatic other_error(input string what);
      other_cnt++;
      $display("ERROR at %0t: %s", $time, what);
   endtask

   task automatic finish_run();
      int asrt_cnt;
      asrt_cnt = psx_pad_top_i.psx_pad_asserts_i.fail_cnt;
      $display("Value errors: %0d, other errors: %0d, assertion failures: %0d",
               value_cnt, other_cnt, asrt_cnt);
      if (value_cnt + other_cnt + asrt_cnt == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   endtask

   // Analog IDs per the pad type rule
   function automatic logic expect_analog(input logic [7:0] id);
      logic [7:0] analog_ids [0:4];
      logic       hit;
      analog_ids = '{8'h23, 8'h53, 8'h73, 8'hE3, 8'hF3};
      hit = 1'b0;
      foreach (analog_ids[i])
         if (id == analog_ids[i]) hit = 1'b1;
      return hit;
   endfunction

   function automatic logic [7:0] expect_cmd(input int idx, input logic [1:0] sw);
      logic [7:0] cmd;
      case (idx)
         0:       cmd = 8'h01;
         1:       cmd = 8'h42;
         3:       cmd = (sw != 2'b00) ? 8'h40 : 8'h00;   // Small motor on
         4:       cmd = (sw != 2'b00) ? 8'h01 : 8'h00;
         default: cmd = 8'h00;
      endcase
      return cmd;
   endfunction

   // Load one stimulus row while the link is idle
   task automatic setup_frame(input int f);
      int base;
      base = f * COLS;
      vib_sw   = stim[base+1][1:0];
      ps_rxd   = 1'b1;
      reply[0] = 8'hFF;
      reply[1] = stim[base];
      reply[2] = 8'h5A;
      for (int i = 0; i < 6; i++)
         reply[3+i] = stim[base+2+i];
      for (int i = 0; i < 9; i++)
         tx_seen[i] = 8'h00;
      bit_cnt = 0;
   endtask

   task automatic check_frame(input int f);
      logic [7:0] id;
      int         exp_len;
      int         n_bytes;
      id      = stim[f*COLS];
      exp_len = expect_analog(id) ? 9 : 5;
      n_bytes = bit_cnt / 8;
      if (bit_cnt % 8 != 0) other_error("frame ended in the middle of a byte");
      if (n_bytes != exp_len) value_error("frame length", 48'(exp_len), 48'(n_bytes));
      if (pad_analog !== expect_analog(id))
         value_error("pad_analog", 48'(expect_analog(id)), 48'(pad_analog));
      for (int i = 0; i < exp_len && i < n_bytes; i++) begin
         if (tx_seen[i] !== expect_cmd(i, vib_sw))
            value_error($sformatf("ps_txd byte %0d", i), 48'(expect_cmd(i, vib_sw)),
                        48'(tx_seen[i]));
      end
   endtask

   // Digital pads deliver bytes 3 and 4 only
   task automatic check_data(input int f);
      logic [47:0] exp_data;
      int          n_data;
      n_data   = expect_analog(stim[f*COLS]) ? 6 : 2;
      exp_data = '0;
      for (int i = 0; i < n_data; i++)
         exp_data[8*i +: 8] = stim[f*COLS + 2 + i];
      if (pad_data !== exp_data) value_error("pad_data", exp_data, pad_data);
   endtask

   // ----------------------------------------
   // Pad model and link monitor
   // ----------------------------------------
   always @(negedge I_CLK) begin
      logic [3:0] byte_no;
      logic [2:0] bit_no;
      if (I_RSTn && !ps_sel && !ps_clk) begin
         byte_no = bit_cnt[6:3];
         bit_no  = bit_cnt[2:0];
         if (byte_no < 4'd9) begin
            ps_rxd = reply[byte_no][bit_no];   // Held until ps_clk rises
            tx_seen[byte_no][bit_no] = ps_txd;
         end
         bit_cnt++;
      end
   end

   always @(negedge I_CLK) begin
      if (I_RSTn) begin
         if (ps_sel && !ps_clk) value_error("ps_clk", 48'(1'b1), 48'(ps_clk));
         if (ps_sel && !ps_txd) value_error("ps_txd", 48'(1'b1), 48'(ps_txd));
         if (pad_data !== last_data && !done_prev) value_error("pad_data", last_data, pad_data);
      end
      last_data = pad_data;
      done_prev = frame_done;   // pad_data moves one cycle after frame_done
   end

   always @(posedge I_CLK) begin
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES) begin
         other_error("timeout, the frames did not complete within the cycle limit");
         finish_run();
      end
   end

   // ----------------------------------------
   // Main sequence
   // ----------------------------------------
   initial begin
      I_RSTn = 1'b0;
      ps_rxd = 1'b1;
      vib_sw = 2'b00;
      $readmemh("tb/pad_stimulus.txt", stim);
      if ($isunknown(stim[NUM_FRAMES*COLS-1])) begin
         other_error("stimulus file is missing or shorter than expected");
      end else begin
         setup_frame(0);
         repeat (2) @(negedge I_CLK);
         I_RSTn = 1'b1;
         for (int f = 0; f < NUM_FRAMES; f++) begin
            do @(negedge I_CLK); while (ps_sel);
            do @(negedge I_CLK); while (!frame_done);
            check_frame(f);
            @(negedge I_CLK);
            check_data(f);
            if (f + 1 < NUM_FRAMES)
               setup_frame(f + 1);
         end
      end
      finish_run();
   end

endmodule

`default_nettype wire

//--- tb/psx_pad_asserts.sv
// Bound checks on select, pad clock, transmit idle level and published data stability
`timescale 1ns/10ps
`default_nettype none

module psx_pad_asserts (
   input logic               I_CLK,
   input logic               I_RSTn,
   input logic               ps_clk,
   input logic               ps_sel,
   input logic               ps_txd,
   input logic               frame_done,
   input psx_pkg::pad_data_t pad_data
);

   int fail_cnt = 0;   // Failed assertions so far

   // Pad clock only toggles inside a poll
   clk_in_frame: assert property (@(posedge I_CLK) disable iff (!I_RSTn)
      !ps_clk |-> !ps_sel)
      else begin
         fail_cnt++;
         $error("ps_clk low while ps_sel is high");
      end

   txd_idle: assert property (@(posedge I_CLK) disable iff (!I_RSTn)
      ps_sel |-> ps_txd)
      else begin
         fail_cnt++;
         $error("ps_txd low while ps_sel is high");
      end

   done_on_rise: assert property (@(posedge I_CLK) disable iff (!I_RSTn)
      frame_done |-> $rose(ps_sel))
      else begin
         fail_cnt++;
         $error("frame_done without ps_sel rising");
      end

   // Store copies on the cycle after frame_done
   data_stable: assert property (@(posedge I_CLK) disable iff (!I_RSTn)
      !$past(frame_done) |-> $stable(pad_data))
      else begin
         fail_cnt++;
         $error("pad_data changed outside frame_done");
      end

endmodule

`default_nettype wire

//--- src/psx_pad_top.sv
// Pad poller top level with frame timer, serial link, command and response store
`timescale 1ns/10ps
`default_nettype none

module psx_pad_top #(
   parameter int TIMER_BITS = 12   // Frame is 2**TIMER_BITS cycles, 9 to 16
) (
   input  logic               I_CLK,
   input  logic               I_RSTn,
   input  logic               ps_rxd,
   input  logic [1:0]         vib_sw,
   output logic               ps_clk,
   output logic               ps_sel,
   output logic               ps_txd,
   output psx_pkg::pad_data_t pad_data,
   output logic               pad_analog,
   output logic               frame_done
);

   // ----------------------------------------
   // Internal strobes and bytes
   // ----------------------------------------
   psx_pkg::byte_idx_t byte_idx;
   psx_pkg::byte_t     tx_byte;
   psx_pkg::byte_t     rx_byte;
   logic               analog;
   logic               tx_load;
   logic               bit_fall;
   logic               bit_rise;
   logic               byte_done;
   logic               frame_start;

   assign pad_analog = analog;

   psx_frame_timer #(
      .TIMER_BITS (TIMER_BITS)
   ) psx_frame_timer_i (
      .I_CLK       (I_CLK),
      .I_RSTn      (I_RSTn),
      .analog      (analog),
      .ps_clk      (ps_clk),
      .ps_sel      (ps_sel),
      .tx_load     (tx_load),
      .bit_fall    (bit_fall),
      .bit_rise    (bit_rise),
      .byte_done   (byte_done),
      .frame_start (frame_start),
      .frame_done  (frame_done),
      .byte_idx    (byte_idx)
   );

   psx_serial_io psx_serial_io_i (
      .I_CLK    (I_CLK),
      .I_RSTn   (I_RSTn),
      .tx_load  (tx_load),
      .bit_fall (bit_fall),
      .bit_rise (bit_rise),
      .tx_byte  (tx_byte),
      .ps_rxd   (ps_rxd),
      .ps_txd   (ps_txd),
      .rx_byte  (rx_byte)
   );

   psx_poll_command psx_poll_command_i (
      .I_CLK     (I_CLK),
      .I_RSTn    (I_RSTn),
      .byte_idx  (byte_idx),
      .byte_done (byte_done),
      .rx_byte   (rx_byte),
      .vib_sw    (vib_sw),
      .tx_byte   (tx_byte),
      .analog    (analog)
   );

   psx_response_store psx_response_store_i (
      .I_CLK       (I_CLK),
      .I_RSTn      (I_RSTn),
      .frame_start (frame_start),
      .byte_done   (byte_done),
      .frame_done  (frame_done),
      .byte_idx    (byte_idx),
      .rx_byte     (rx_byte),
      .pad_data    (pad_data)
   );

endmodule

`default_nettype wire

//--- src/psx_response_store.sv
// Shadow capture of response bytes 3 to 8 and end-of-frame publication
`timescale 1ns/10ps
`default_nettype none

module psx_response_store (
   input  logic               I_CLK,
   input  logic               I_RSTn,
   input  logic               frame_start,
   input  logic               byte_done,
   input  logic               frame_done,
   input  psx_pkg::byte_idx_t byte_idx,
   input  psx_pkg::byte_t     rx_byte,
   output psx_pkg::pad_data_t pad_data
);

   psx_pkg::pad_data_t shadow;

   // Cleared each frame, so a digital pad leaves the upper entries zero
   always_ff @(posedge I_CLK) begin
      if (frame_start) begin
         shadow <= '0;
      end else if (byte_done) begin
         for (int i = 0; i < psx_pkg::DATA_BYTES; i++) begin
            if (byte_idx == psx_pkg::byte_idx_t'(psx_pkg::FIRST_DATA_IDX + i))
               shadow[i] <= rx_byte;
         end
      end
   end

   // Whole set moves at once, never a half-updated frame
   always_ff @(posedge I_CLK or negedge I_RSTn) begin
      if (!I_RSTn)
         pad_data <= '0;
      else if (frame_done)
         pad_data <= shadow;
   end

endmodule

`default_nettype wire

//--- src/psx_poll_command.sv
// Read-command byte selection, vibration request and pad-type detection
`timescale 1ns/10ps
`default_nettype none

module psx_poll_command (
   input  logic               I_CLK,
   input  logic               I_RSTn,
   input  psx_pkg::byte_idx_t byte_idx,
   input  logic               byte_done,
   input  psx_pkg::byte_t     rx_byte,
   input  logic [1:0]         vib_sw,
   output psx_pkg::byte_t     tx_byte,
   output logic               analog
);

   // Byte positions within the poll
   localparam psx_pkg::byte_idx_t IDX_START = 4'd0;
   localparam psx_pkg::byte_idx_t IDX_READ  = 4'd1;   // Pad answers with its ID here
   localparam psx_pkg::byte_idx_t IDX_SMALL = 4'd3;
   localparam psx_pkg::byte_idx_t IDX_PARAM = 4'd4;

   logic vib_on;

   assign vib_on = |vib_sw;   // Either switch drives the small motor

   // ----------------------------------------
   // Command byte for the current slot
   // ----------------------------------------
   // byte_idx moves at slot start, tx_load comes a few cycles later
   always_ff @(posedge I_CLK or negedge I_RSTn) begin
      if (!I_RSTn) begin
         tx_byte <= '0;
      end else begin
         case (byte_idx)
            IDX_START: tx_byte <= psx_pkg::CMD_START;
            IDX_READ:  tx_byte <= psx_pkg::CMD_READ;
            IDX_SMALL: tx_byte <= vib_on ? psx_pkg::CMD_VIB_SMALL_ON : '0;
            IDX_PARAM: tx_byte <= vib_on ? psx_pkg::CMD_VIB_PARAM_ON : '0;
            default:   tx_byte <= '0;
         endcase
      end
   end

   // Pad type from the ID byte, sets this frame's length
   always_ff @(posedge I_CLK or negedge I_RSTn) begin
      if (!I_RSTn)
         analog <= 1'b0;
      else if (byte_done && (byte_idx == IDX_READ))
         analog <= psx_pkg::is_analog_id(rx_byte);
   end

endmodule

`default_nettype wire

//--- link/psx_serial_io.sv
// Transmit and receive shift registers for one byte slot, LSB first
`timescale 1ns/10ps
`default_nettype none

module psx_serial_io (
   input  logic           I_CLK,
   input  logic           I_RSTn,
   input  logic           tx_load,
   input  logic           bit_fall,
   input  logic           bit_rise,
   input  psx_pkg::byte_t tx_byte,
   input  logic           ps_rxd,
   output logic           ps_txd,
   output psx_pkg::byte_t rx_byte
);

   psx_pkg::byte_t tx_shift;

   // ----------------------------------------
   // Transmit
   // ----------------------------------------
   // Loaded at LOAD_PHASE, then one bit per bit_fall.
   // Ones fill from the top, so the ninth step
   // puts the line back to idle high
   always_ff @(posedge I_CLK or negedge I_RSTn) begin
      if (!I_RSTn) begin
         tx_shift <= '1;
         ps_txd   <= 1'b1;   // Idle level
      end else if (tx_load) begin
         tx_shift <= tx_byte;
      end else if (bit_fall) begin
         ps_txd   <= tx_shift[0];
         tx_shift <= {1'b1, tx_shift[7:1]};
      end
   end

   // ----------------------------------------
   // Receive
   // ----------------------------------------
   // New bit enters at the top, first bit ends at bit 0
   always_ff @(posedge I_CLK) begin
      if (bit_rise)
         rx_byte <= {ps_rxd, rx_byte[7:1]};
   end

endmodule

`default_nettype wire

//--- link/psx_frame_timer.sv
// Free-running frame timer with slot decode, ps_sel, ps_clk and link strobes
`timescale 1ns/10ps
`default_nettype none

module psx_frame_timer #(
   parameter int TIMER_BITS = 12
) (
   input  logic               I_CLK,
   input  logic               I_RSTn,
   input  logic               analog,
   output logic               ps_clk,
   output logic               ps_sel,
   output logic               tx_load,
   output logic               bit_fall,
   output logic               bit_rise,
   output logic               byte_done,
   output logic               frame_start,
   output logic               frame_done,
   output psx_pkg::byte_idx_t byte_idx
);

   localparam int SLOT_W = TIMER_BITS - psx_pkg::SLOT_BITS;

   typedef logic [psx_pkg::SLOT_BITS-1:0] phase_t;

   logic [TIMER_BITS-1:0] frame_cnt;
   logic [SLOT_W-1:0]     slot;
   logic [SLOT_W-1:0]     frame_len;
   phase_t                phase;
   phase_t                next_phase;
   logic                  slot_active;
   logic                  in_bits;
   logic                  clk_low;
   logic                  tx_step;

   // One frame per counter wrap
   always_ff @(posedge I_CLK or negedge I_RSTn) begin
      if (!I_RSTn)
         frame_cnt <= '0;
      else
         frame_cnt <= frame_cnt + 1'b1;
   end

   assign slot       = frame_cnt[TIMER_BITS-1 -: SLOT_W];
   assign phase      = frame_cnt[psx_pkg::SLOT_BITS-1:0];
   assign next_phase = phase + 1'b1;

   // Length may grow to 9 once the ID byte of this frame is known
   assign frame_len   = analog ? SLOT_W'(psx_pkg::ANALOG_BYTES) : SLOT_W'(psx_pkg::DIGITAL_BYTES);
   assign slot_active = (slot < frame_len);

   // ----------------------------------------
   // Bit window decode
   // ----------------------------------------
   assign in_bits = (phase >= psx_pkg::FIRST_BIT_PHASE) && (phase < psx_pkg::DONE_PHASE);
   assign clk_low = slot_active && in_bits && !phase[0];   // First cycle of each bit

   // ps_txd steps one cycle ahead of each ps_clk fall,
   // extra step at DONE_PHASE shifts out the fill and returns the line high
   assign tx_step = slot_active && !next_phase[0]
                    && (next_phase >= psx_pkg::FIRST_BIT_PHASE)
                    && (next_phase <= psx_pkg::DONE_PHASE);

   // ----------------------------------------
   // Registered link outputs and strobes
   // ----------------------------------------
   always_ff @(posedge I_CLK or negedge I_RSTn) begin
      if (!I_RSTn) begin
         ps_sel      <= 1'b1;
         ps_clk      <= 1'b1;
         tx_load     <= 1'b0;
         bit_fall    <= 1'b0;
         bit_rise    <= 1'b0;
         byte_done   <= 1'b0;
         frame_start <= 1'b0;
         frame_done  <= 1'b0;
         byte_idx    <= '0;
      end else begin
         ps_sel      <= !slot_active;
         ps_clk      <= !clk_low;
         tx_load     <= slot_active && (phase == psx_pkg::LOAD_PHASE);
         bit_fall    <= tx_step;
         bit_rise    <= clk_low;   // Pad data sampled as ps_clk rises
         byte_done   <= slot_active && (phase == psx_pkg::DONE_PHASE);
         frame_start <= (frame_cnt == '0);
         frame_done  <= !slot_active && !ps_sel;   // Same cycle ps_sel goes high
         byte_idx    <= slot[psx_pkg::BYTE_IDX_W-1:0];
      end
   end

endmodule

`default_nettype wire

//--- common/psx_pkg.sv
// Pad link constants, byte and index types, frame lengths, command bytes, pad ID decode
`default_nettype none

package psx_pkg;

   // ----------------------------------------
   // Slot and frame geometry
   // ----------------------------------------
   localparam int unsigned SLOT_BITS  = 5;   // 32 cycles per byte slot
   localparam int unsigned BYTE_IDX_W = 4;

   typedef logic [7:0]            byte_t;
   typedef logic [BYTE_IDX_W-1:0] byte_idx_t;

   localparam int unsigned DIGITAL_BYTES  = 5;
   localparam int unsigned ANALOG_BYTES   = 9;
   localparam int unsigned FIRST_DATA_IDX = 3;   // After FF, ID and 5A
   localparam int unsigned DATA_BYTES     = 6;

   // Entry 0 holds response byte 3
   typedef byte_t [DATA_BYTES-1:0] pad_data_t;

   // Phases inside one slot
   localparam logic [SLOT_BITS-1:0] LOAD_PHASE      = SLOT_BITS'(4);
   localparam logic [SLOT_BITS-1:0] FIRST_BIT_PHASE = SLOT_BITS'(8);
   localparam logic [SLOT_BITS-1:0] DONE_PHASE      = SLOT_BITS'(24);

   // ----------------------------------------
   // Read command bytes
   // ----------------------------------------
   localparam byte_t CMD_START        = 8'h01;
   localparam byte_t CMD_READ         = 8'h42;
   localparam byte_t CMD_VIB_SMALL_ON = 8'h40;
   localparam byte_t CMD_VIB_PARAM_ON = 8'h01;

   // Analog pads report one of these IDs, everything else is treated as digital
   function automatic logic is_analog_id(byte_t id);
      logic analog;
      case (id)
         8'h23, 8'h53, 8'h73, 8'hE3, 8'hF3: analog = 1'b1;
         default:                           analog = 1'b0;
      endcase
      return analog;
   endfunction

endpackage

`default_nettype wire
